// ==== verif/fib_testdata.txt ====
# expected segment words for F0 to F15 in hex, thousands byte first
# then runs: test name, ready mode (0 held high, 1 lfsr), extra start (1 pulses during RUN)
ffffff03  # 0
ffffff9f  # 1
ffffff9f  # 1
ffffff25  # 2
ffffff0d  # 3
ffffff49  # 5
ffffff01  # 8
ffff9f0d  # 13
ffff259f  # 21
ffff0d99  # 34
ffff4949  # 55
ffff0109  # 89
ff9f9999  # 144
ff250d0d  # 233
ff0d1f1f  # 377
ff419f03  # 610

ready_high    0 0
ready_lfsr    1 0
start_in_run  1 1
repeat_high   0 0

// ==== vlog.f ====
+incdir+design
design/fib_pkg.sv
design/fib_sequencer.sv
design/digit_stage.sv
design/seg_encoder.sv
design/fib_display_top.sv
verif/tb_fib_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns -f vlog.f \
    --top-module tb_fib_display -o sim_fib \
    && ./obj_dir/sim_fib | tee sim.log \
    && grep -q "^Simulation PASSED$" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

// ==== verif/tb_fib_display.sv ====
`timescale 1ns/1ns
`include "fib_params.svh"

module tb_fib_display;

    logic               clk;
    logic               rst;
    logic               start;
    logic               busy;
    logic               out_valid;
    logic               out_ready;
    fib_pkg::seg_word_t out_segs;

    logic [31:0]        expected [`FIB_TERMS];  // one word per term as read from the data file
    string              run_name [$];
    int                 run_mode [$];           // 0 ready held high, 1 lfsr ready
    int                 run_extra [$];          // 1 pulses start during RUN
    string              cur_name = "idle";
    logic [31:0]        lfsr_state;
    int                 ready_mode;
    logic [31:0]        held_word = '0;
    logic               hold_seen = 1'b0;       // stalled word seen last cycle
    int                 total_words = 0;
    int                 word_base = 0;          // total_words when the run began
    int                 main_errors = 0;
    int                 mon_errors = 0;
    int                 main_checks = 0;
    int                 mon_checks = 0;
    int                 limit_cycles = 0;
    logic               watchdog_armed = 1'b0;

    fib_display_top dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .busy      (busy),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_segs  (out_segs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            lfsr_step = (s >> 1) ^ 32'h80200003;
        end else begin
            lfsr_step = s >> 1;
        end
    endfunction

    // one clock and then ready driven just after the edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
        if (ready_mode == 1) begin
            out_ready  = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);  // one step per ready bit
        end else begin
            out_ready = 1'b1;
        end
    endtask

    // ---------------------------------------------------------------------------
    // data file with the expected words first and one line per run after them
    // ---------------------------------------------------------------------------
    task automatic load_testdata();
        int              fd;
        int              n_words;
        int              n_read;
        int              mode_val;
        int              extra_val;
        logic            skip;
        logic [31:0]     word_val;
        logic [8*24-1:0] name_val;
        string           line;
        n_words = 0;
        fd = $fopen("verif/fib_testdata.txt", "r");
        if (fd == 0) begin
            $display("Error: could not open verif/fib_testdata.txt");
            main_errors++;
        end else begin
            while (!$feof(fd)) begin
                line   = "";
                n_read = $fgets(line, fd);
                skip   = (n_read == 0) || (line.len() == 0) || (line.getc(0) == "#")
                         || (line.getc(0) == "\n") || (line.getc(0) == "\r");
                if (!skip && n_words < `FIB_TERMS) begin
                    if ($sscanf(line, "%h", word_val) == 1) begin
                        expected[n_words] = word_val;
                        n_words++;
                    end
                end else if (!skip) begin
                    if ($sscanf(line, "%s %d %d", name_val, mode_val, extra_val) == 3) begin
                        run_name.push_back($sformatf("%0s", name_val));
                        run_mode.push_back(mode_val);
                        run_extra.push_back(extra_val);
                    end
                end
            end
            $fclose(fd);
        end
        if (n_words != `FIB_TERMS || run_name.size() == 0) begin
            $display("Error: test data incomplete, %0d words and %0d runs read",
                     n_words, run_name.size());
            main_errors++;
        end
    endtask

    task automatic run_test(input int idx);
        int wait_cycles;
        int drain_cycles;
        int busy_cycles;  // samples with busy high since the start edge
        int got;
        cur_name   = run_name[idx];
        ready_mode = run_mode[idx];
        word_base  = total_words;
        start      = 1'b1;
        step_cycle();  // start sampled here
        start = 1'b0;
        main_checks++;
        if (busy !== 1'b1) begin
            $display("Error: %0s busy expected 1 actual %b", cur_name, busy);
            main_errors++;
        end
        busy_cycles = 1;
        wait_cycles = 0;
        while (out_valid !== 1'b1 && wait_cycles < 20) begin
            step_cycle();
            wait_cycles++;
            if (busy === 1'b1) begin
                busy_cycles++;
            end
        end
        main_checks++;
        if (wait_cycles != 6) begin
            $display("Error: %0s first word latency expected 6 actual %0d",
                     cur_name, wait_cycles);
            main_errors++;
        end
        if (run_extra[idx] != 0) begin
            while ((total_words - word_base) < 2) begin
                step_cycle();
            end
            main_checks++;
            if (busy !== 1'b1) begin
                $display("Error: %0s busy before the extra start expected 1 actual %b",
                         cur_name, busy);
                main_errors++;
            end
            start = 1'b1;  // must be ignored outside IDLE
            step_cycle();
            start = 1'b0;
        end
        drain_cycles = 0;
        while ((total_words - word_base) < `FIB_TERMS || busy || out_valid) begin
            step_cycle();
            drain_cycles++;
            if (busy === 1'b1) begin
                busy_cycles++;
            end
        end
        // with ready held high one word leaves every cycle
        if (run_mode[idx] == 0 && run_extra[idx] == 0) begin
            main_checks++;
            if (drain_cycles != `FIB_TERMS) begin
                $display("Error: %0s drain cycles expected %0d actual %0d",
                         cur_name, `FIB_TERMS, drain_cycles);
                main_errors++;
            end
            main_checks++;
            if (busy_cycles != `FIB_TERMS + 2) begin  // LOAD and the term register
                $display("Error: %0s busy cycles expected %0d actual %0d",
                         cur_name, `FIB_TERMS + 2, busy_cycles);
                main_errors++;
            end
        end
        // drained so nothing else should come out
        ready_mode = 0;
        repeat (12) begin
            step_cycle();
            main_checks++;
            if (busy !== 1'b0 || out_valid !== 1'b0) begin
                $display("Error: %0s busy expected 0 actual %b out_valid expected 0 actual %b",
                         cur_name, busy, out_valid);
                main_errors++;
            end
        end
        got = total_words - word_base;
        main_checks++;
        if (got != `FIB_TERMS) begin
            $display("Error: %0s word count expected %0d actual %0d", cur_name, `FIB_TERMS, got);
            main_errors++;
        end
    endtask

    // ---------------------------------------------------------------------------
    // output monitor sampled mid-cycle where all signals are settled
    // ---------------------------------------------------------------------------
    always @(negedge clk) begin : output_monitor
        int idx;
        if (!rst) begin
            if (hold_seen) begin
                mon_checks++;
                if (out_valid !== 1'b1 || out_segs !== held_word) begin
                    $display("Error: %0s stalled word expected %h actual %h",
                             cur_name, held_word, out_segs);
                    mon_errors++;
                end
            end
            hold_seen = out_valid && !out_ready;
            held_word = out_segs;
            if (out_valid && out_ready) begin  // transfer on the next edge
                idx = total_words - word_base;
                mon_checks++;
                if (idx >= `FIB_TERMS) begin
                    $display("Error: %0s produced word %0d beyond the end of the run",
                             cur_name, idx);
                    mon_errors++;
                end else if (out_segs !== expected[idx]) begin
                    $display("Error: %0s word %0d expected %h actual %h",
                             cur_name, idx, expected[idx], out_segs);
                    mon_errors++;
                end
                total_words++;
            end
        end
    end

    initial begin
        wait (watchdog_armed);
        repeat (limit_cycles) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles, run did not complete",
                 limit_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        out_ready  = 1'b0;
        ready_mode = 0;
        lfsr_state = 32'h21362447;
        load_testdata();
        limit_cycles   = run_name.size() * `FIB_TERMS * 40 + 100;
        watchdog_armed = 1'b1;
        repeat (2) step_cycle();
        rst = 1'b0;
        repeat (10) begin  // quiet until the first start
            step_cycle();
            main_checks++;
            if (busy !== 1'b0 || out_valid !== 1'b0) begin
                $display("Error: %0s busy expected 0 actual %b out_valid expected 0 actual %b",
                         cur_name, busy, out_valid);
                main_errors++;
            end
        end
        for (int i = 0; i < run_name.size(); i++) begin
            run_test(i);
        end
        $display("checks %0d, errors %0d", main_checks + mon_checks, main_errors + mon_errors);
        if (main_errors + mon_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== design/fib_display_top.sv ====
`timescale 1ns/1ns
`include "fib_params.svh"

module fib_display_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    output logic               busy,
    output logic               out_valid,
    input  logic               out_ready,
    output fib_pkg::seg_word_t out_segs
);

    // link 0 leaves the sequencer, link k+1 leaves digit stage k
    logic [`FIB_DIGITS-1:0]  link_valid;
    logic [`FIB_DIGITS-1:0]  link_ready;
    fib_pkg::digit_work_t    link_work [`FIB_DIGITS];

    fib_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .busy       (busy),
        .term_valid (link_valid[0]),
        .term_ready (link_ready[0]),
        .term       (link_work[0])
    );

    // ---------------------------------------------------------------------------
    // one stage per decimal power, most significant first
    // ---------------------------------------------------------------------------
    for (genvar k = 0; k < `FIB_DIGITS-1; k++) begin : g_digit
        digit_stage #(
            .POWER (10 ** (`FIB_DIGITS-1-k))  // 1000, 100, 10
        ) u_stage (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (link_valid[k]),
            .in_ready  (link_ready[k]),
            .in_work   (link_work[k]),
            .out_valid (link_valid[k+1]),
            .out_ready (link_ready[k+1]),
            .out_work  (link_work[k+1])
        );
    end

    seg_encoder u_enc (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (link_valid[`FIB_DIGITS-1]),
        .in_ready  (link_ready[`FIB_DIGITS-1]),
        .in_work   (link_work[`FIB_DIGITS-1]),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_segs  (out_segs)
    );

endmodule

// ==== design/seg_encoder.sv ====
`timescale 1ns/1ns
`include "fib_params.svh"

module seg_encoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  fib_pkg::digit_work_t in_work,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fib_pkg::seg_word_t   out_segs
);

    logic [4*`FIB_DIGITS-1:0] bcd_all;
    fib_pkg::seg_word_t       seg_next;

    // active low, decimal point held off
    function automatic logic [`SEG_WIDTH-1:0] seg_code(input logic [3:0] nib);
        case (nib)
            4'd0:    seg_code = 8'h03;
            4'd1:    seg_code = 8'h9F;
            4'd2:    seg_code = 8'h25;
            4'd3:    seg_code = 8'h0D;
            4'd4:    seg_code = 8'h99;
            4'd5:    seg_code = 8'h49;
            4'd6:    seg_code = 8'h41;
            4'd7:    seg_code = 8'h1F;
            4'd8:    seg_code = 8'h01;
            4'd9:    seg_code = 8'h09;
            default: seg_code = 8'hFF;  // blank
        endcase
    endfunction

    // leftover remainder is the ones digit, never blanked
    assign bcd_all = {in_work.digits[4*`FIB_DIGITS-5:0], in_work.remainder[3:0]};

    always_comb begin
        for (int i = 0; i < `FIB_DIGITS; i++) begin
            seg_next[i] = seg_code(bcd_all[4*i +: 4]);
        end
    end

    // ---------------------------------------------------------------------------
    // output register
    // ---------------------------------------------------------------------------
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_segs <= seg_next;
        end
    end

endmodule

// ==== design/digit_stage.sv ====
`timescale 1ns/1ns
`include "fib_params.svh"

module digit_stage #(
    parameter int POWER = 10  // decimal weight of the digit found here
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  fib_pkg::digit_work_t in_work,
    output logic                 out_valid,
    input  logic                 out_ready,
    output fib_pkg::digit_work_t out_work
);

    logic [3:0]             digit;
    logic [3:0]             nibble;     // digit or blank code
    logic                   lead_next;
    logic [`FIB_WIDTH-1:0]  rem_next;
    int                     sub;

    // ---------------------------------------------------------------------------
    // digit search, largest d with d*POWER <= remainder
    // ---------------------------------------------------------------------------
    always_comb begin
        digit = 4'd0;
        for (int d = 1; d <= 9; d++) begin
            if (int'(in_work.remainder) >= d * POWER) begin
                digit = 4'(d);
            end
        end
    end

    assign sub       = int'(digit) * POWER;
    assign rem_next  = in_work.remainder - `FIB_WIDTH'(sub);
    assign lead_next = in_work.lead && (digit == 4'd0);
    assign nibble    = lead_next ? 4'hF : digit;  // still leading, so blank

    // single output register
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_work.remainder <= rem_next;
            out_work.digits    <= {in_work.digits[4*`FIB_DIGITS-5:0], nibble};
            out_work.lead      <= lead_next;
        end
    end

endmodule

// ==== design/fib_sequencer.sv ====
`timescale 1ns/1ns
`include "fib_params.svh"

module fib_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output logic                 busy,
    output logic                 term_valid,
    input  logic                 term_ready,
    output fib_pkg::digit_work_t term
);

    fib_pkg::seq_state_e         state;
    logic [`FIB_WIDTH-1:0]       older;     // term offered next
    logic [`FIB_WIDTH-1:0]       newer;     // the one after it
    logic [`TERM_CNT_WIDTH-1:0]  term_cnt;  // terms pushed to the output register
    logic                        all_issued;
    logic                        issue;
    logic                        last_done;

    assign busy       = (state != fib_pkg::IDLE);
    assign all_issued = (term_cnt == `TERM_CNT_WIDTH'(`FIB_TERMS));

    // output register free, or emptying on this edge
    assign issue = (state == fib_pkg::RUN) && !all_issued && (!term_valid || term_ready);

    // final term leaves for the first digit stage
    assign last_done = all_issued && term_valid && term_ready;

    // ---------------------------------------------------------------------------
    // control FSM and term counter
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= fib_pkg::IDLE;
            term_valid <= 1'b0;
            term_cnt   <= '0;
        end else begin
            case (state)
                fib_pkg::IDLE: begin
                    if (start) begin  // start only looked at here
                        state <= fib_pkg::LOAD;
                    end
                end
                fib_pkg::LOAD: begin
                    state    <= fib_pkg::RUN;
                    term_cnt <= '0;
                end
                fib_pkg::RUN: begin
                    if (last_done) begin
                        state <= fib_pkg::IDLE;
                    end
                end
                default: state <= fib_pkg::IDLE;
            endcase

            if (issue) begin
                term_valid <= 1'b1;
                term_cnt   <= term_cnt + `TERM_CNT_WIDTH'(1);
            end else if (term_valid && term_ready) begin
                term_valid <= 1'b0;
            end
        end
    end

    // ---------------------------------------------------------------------------
    // fibonacci pair
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == fib_pkg::LOAD) begin
            older <= '0;                 // F0
            newer <= `FIB_WIDTH'(1);     // F1
        end else if (issue) begin
            older <= newer;
            newer <= older + newer;
        end
    end

    // term handed to the digit pipeline, held until taken
    always_ff @(posedge clk) begin
        if (issue) begin
            term.remainder <= older;
            term.digits    <= '0;
            term.lead      <= 1'b1;
        end
    end

endmodule

// ==== design/fib_pkg.sv ====
`include "fib_params.svh"

package fib_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,  // seed the two term registers
        RUN  = 2'd2
    } seq_state_e;

    // ---------------------------------------------------------------------------
    // record that moves down the digit pipeline
    // ---------------------------------------------------------------------------
    typedef struct packed {
        logic [`FIB_WIDTH-1:0]      remainder;  // part of the term still to convert
        logic [4*`FIB_DIGITS-1:0]   digits;     // bcd so far, 4'hF marks a blank
        logic                       lead;       // all digits so far were zero
    } digit_work_t;

    // one active-low segment byte per digit, thousands in the top byte
    typedef logic [`FIB_DIGITS-1:0][`SEG_WIDTH-1:0] seg_word_t;

endpackage

// ==== design/fib_params.svh ====
`ifndef FIB_PARAMS_SVH
`define FIB_PARAMS_SVH

// ---------------------------------------------------------------------------
// term generation
// ---------------------------------------------------------------------------

`define FIB_WIDTH       11  // bits per term
`define FIB_TERMS       16  // terms per run, keep at 17 or below for 11-bit terms
`define TERM_CNT_WIDTH  5   // must reach FIB_TERMS

// ---------------------------------------------------------------------------
// display side
// ---------------------------------------------------------------------------

`define FIB_DIGITS      4   // decimal digits shown
`define SEG_WIDTH       8   // segment byte, bit 0 is the decimal point

`endif
